/* boot_rom.hex */
// one 64-bit boot ROM word per line, word index 0 first
00000297_02028593
0182b283_00028067
f1402573_00050463
10500073_ffdff06f
0000_0013_0000_0013
8badf00d_1234abcd
0123_4567_89ab_cdef
fedc_ba98_7654_3210
13579bdf_2468ace0
a5a5a5a5_5a5a5a5a
0f1e2d3c_4b5a6978
deadbeef_cafef00d
00000000_00000001
ffffffff_fffffffe
55aa55aa_aa55aa55
7e6d5c4b_3a291807

/* periph_subsystem.f */
rtl/soc_map_pkg.sv
rtl/soc_bus_pkg.sv
rtl/boot_rom.sv
rtl/clint_timer.sv
rtl/periph_router.sv
rtl/periph_subsystem.sv
verif/periph_subsystem_asserts.sv
verif/tb_periph_subsystem.sv

/* rtl/boot_rom.sv */
`timescale 1ns/10ps

module boot_rom #(
  parameter int unsigned RomWords = 16
) (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o
);

  localparam int unsigned IdxWidth = (RomWords > 1) ? $clog2(RomWords) : 1;

  logic [soc_bus_pkg::DataWidth-1:0] mem [RomWords];

  logic [31:0]                       word_idx;
  logic                              in_range;
  logic                              rvalid_q;
  logic                              err_q;
  logic [soc_bus_pkg::DataWidth-1:0] rdata_q;

  // contents come from the boot image
  initial begin
    $readmemh("boot_rom.hex", mem);
  end

  assign word_idx = 32'(req_i.addr.rom.word_idx);
  // words past the image read back as zero
  assign in_range = (word_idx < RomWords);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      // read-only, any write is refused
      err_q    <= req_i.req & req_i.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= (!req_i.we && in_range) ? mem[word_idx[IdxWidth-1:0]] : '0;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.err    = err_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

/* rtl/clint_timer.sv */
`timescale 1ns/10ps

module clint_timer #(
  parameter int unsigned NrHarts = 2
) (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  output logic [NrHarts-1:0]    timer_irq_o,
  output logic [NrHarts-1:0]    ipi_o
);

  localparam int unsigned HartW   = (NrHarts > 1) ? $clog2(NrHarts) : 1;
  localparam logic [12:0] HartCnt = 13'(NrHarts);

  // rtc tick path
  logic [1:0]                   rtc_sync_q;
  logic                         rtc_prev_q;
  logic                         rtc_rise;
  logic                         div_q;
  logic                         tick;

  // registers
  logic [63:0]                  mtime_q;
  logic [NrHarts-1:0][63:0]     mtimecmp_q;
  logic [NrHarts-1:0]           msip_q;
  logic [NrHarts-1:0]           timer_irq_q;

  // decode
  logic [15:0]                  word_off;
  logic [15:0]                  msip_rel;
  logic [15:0]                  cmp_rel;
  logic                         msip_hit;
  logic                         cmp_hit;
  logic                         mtime_hit;
  logic                         reg_hit;
  logic [HartW-1:0]             msip_hart;
  logic [HartW-1:0]             cmp_hart;
  logic                         wr_en;
  logic [63:0]                  rdata_d;

  // response
  logic                         rvalid_q;
  logic                         err_q;
  logic [63:0]                  rdata_q;

  // ------------------------------------------------------------------
  // real-time tick
  // ------------------------------------------------------------------
  // two flops into clk_i, then a rising edge detector
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      div_q      <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        div_q <= ~div_q;
      end
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;
  // every second rtc edge advances mtime
  assign tick     = rtc_rise & div_q;

  // ------------------------------------------------------------------
  // register decode
  // ------------------------------------------------------------------
  assign word_off  = {req_i.addr.clint.bank, req_i.addr.clint.reg_idx, 3'b000};
  // offsets below a block base wrap and miss
  assign msip_rel  = word_off - soc_map_pkg::MsipOffset;
  assign cmp_rel   = word_off - soc_map_pkg::MtimecmpOffset;
  assign msip_hit  = (msip_rel[15:3] < HartCnt);
  assign cmp_hit   = (cmp_rel[15:3] < HartCnt);
  assign mtime_hit = (word_off == soc_map_pkg::MtimeOffset);
  assign reg_hit   = msip_hit | cmp_hit | mtime_hit;
  assign msip_hart = msip_rel[3 +: HartW];
  assign cmp_hart  = cmp_rel[3 +: HartW];
  assign wr_en     = req_i.req & req_i.we & reg_hit;

  always_comb begin
    rdata_d = '0;
    if (mtime_hit) begin
      rdata_d = mtime_q;
    end else if (cmp_hit) begin
      rdata_d = mtimecmp_q[cmp_hart];
    end else if (msip_hit) begin
      rdata_d = {63'd0, msip_q[msip_hart]};
    end
  end

  // ------------------------------------------------------------------
  // timer and software interrupt registers
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= '0;
    end else begin
      // a bus write wins over the tick
      if (wr_en && mtime_hit) begin
        mtime_q <= req_i.wdata;
      end else if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      for (int h = 0; h < NrHarts; h++) begin
        if (wr_en && cmp_hit && cmp_hart == HartW'(h)) begin
          mtimecmp_q[h] <= req_i.wdata;
        end
        if (wr_en && msip_hit && msip_hart == HartW'(h)) begin
          msip_q[h] <= req_i.wdata[0];
        end
      end
    end
  end

  // registered compare per hart
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      timer_irq_q <= '0;
    end else begin
      for (int h = 0; h < NrHarts; h++) begin
        timer_irq_q[h] <= (mtime_q >= mtimecmp_q[h]);
      end
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

  // ------------------------------------------------------------------
  // bus response
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      err_q    <= req_i.req & ~reg_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= (!req_i.we && reg_hit) ? rdata_d : '0;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.err    = err_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

/* rtl/periph_router.sv */
`timescale 1ns/10ps

module periph_router (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  soc_bus_pkg::bus_req_t bus_req_i,
  output soc_bus_pkg::bus_rsp_t bus_rsp_o,
  output soc_bus_pkg::bus_req_t rom_req_o,
  input  soc_bus_pkg::bus_rsp_t rom_rsp_i,
  output soc_bus_pkg::bus_req_t clint_req_o,
  input  soc_bus_pkg::bus_rsp_t clint_rsp_i
);

  logic [soc_bus_pkg::AddrWidth-1:0] addr;
  logic                              rom_match;
  logic                              clint_match;
  soc_map_pkg::region_e              region_d;
  soc_map_pkg::region_e              region_q;
  logic                              dec_err_d;
  logic                              dec_err_q;

  // ------------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------------
  assign addr = bus_req_i.addr.raw;

  // offset from base, so an address below base wraps and misses
  assign rom_match   = ((addr - soc_map_pkg::RomBase) < soc_map_pkg::RomLength);
  assign clint_match = ((addr - soc_map_pkg::ClintBase) < soc_map_pkg::ClintLength);

  always_comb begin
    region_d = soc_map_pkg::REGION_NONE;
    if (rom_match) begin
      region_d = soc_map_pkg::REGION_ROM;
    end else if (clint_match) begin
      region_d = soc_map_pkg::REGION_CLINT;
    end
  end

  assign dec_err_d = bus_req_i.req & (region_d == soc_map_pkg::REGION_NONE);

  // ------------------------------------------------------------------
  // request steering
  // ------------------------------------------------------------------
  // both targets see the payload, only one sees the strobe
  always_comb begin
    rom_req_o       = bus_req_i;
    rom_req_o.req   = bus_req_i.req & (region_d == soc_map_pkg::REGION_ROM);
    clint_req_o     = bus_req_i;
    clint_req_o.req = bus_req_i.req & (region_d == soc_map_pkg::REGION_CLINT);
  end

  // ------------------------------------------------------------------
  // response selection
  // ------------------------------------------------------------------
  // targets answer in one cycle, so one stage tracks the request in flight
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      region_q  <= soc_map_pkg::REGION_NONE;
      dec_err_q <= 1'b0;
    end else begin
      region_q  <= bus_req_i.req ? region_d : soc_map_pkg::REGION_NONE;
      dec_err_q <= dec_err_d;
    end
  end

  always_comb begin
    case (region_q)
      soc_map_pkg::REGION_ROM: begin
        bus_rsp_o = rom_rsp_i;
      end
      soc_map_pkg::REGION_CLINT: begin
        bus_rsp_o = clint_rsp_i;
      end
      default: begin
        // unmapped access, or idle when no error is pending
        bus_rsp_o.rvalid = dec_err_q;
        bus_rsp_o.err    = dec_err_q;
        bus_rsp_o.rdata  = '0;
      end
    endcase
  end

endmodule

/* rtl/periph_subsystem.sv */
`timescale 1ns/10ps

module periph_subsystem #(
  parameter int unsigned NrHarts  = 2,
  parameter int unsigned RomWords = 16
) (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  input  soc_bus_pkg::bus_req_t bus_req_i,
  output soc_bus_pkg::bus_rsp_t bus_rsp_o,
  output logic [NrHarts-1:0]    timer_irq_o,
  output logic [NrHarts-1:0]    ipi_o
);

  soc_bus_pkg::bus_req_t rom_req;
  soc_bus_pkg::bus_rsp_t rom_rsp;
  soc_bus_pkg::bus_req_t clint_req;
  soc_bus_pkg::bus_rsp_t clint_rsp;

  // ------------------------------------------------------------------
  // address map
  // ------------------------------------------------------------------
  periph_router i_periph_router (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .bus_req_i   ( bus_req_i  ),
    .bus_rsp_o   ( bus_rsp_o  ),
    .rom_req_o   ( rom_req    ),
    .rom_rsp_i   ( rom_rsp    ),
    .clint_req_o ( clint_req  ),
    .clint_rsp_i ( clint_rsp  )
  );

  // ------------------------------------------------------------------
  // boot ROM
  // ------------------------------------------------------------------
  boot_rom #(
    .RomWords ( RomWords )
  ) i_boot_rom (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( rom_req    ),
    .rsp_o      ( rom_rsp    )
  );

  // ------------------------------------------------------------------
  // CLINT
  // ------------------------------------------------------------------
  clint_timer #(
    .NrHarts ( NrHarts )
  ) i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .rsp_o       ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

/* rtl/soc_bus_pkg.sv */
package soc_bus_pkg;

  // ------------------------------------------------------------------
  // bus widths
  // ------------------------------------------------------------------
  localparam int unsigned DataWidth = 64;
  localparam int unsigned AddrWidth = 32;

  // ------------------------------------------------------------------
  // request channel
  // ------------------------------------------------------------------
  // req is a single-cycle strobe, no handshake
  // every access moves a full 64-bit word
  typedef struct packed {
    logic                   req;
    logic                   we;
    soc_map_pkg::soc_addr_u addr;
    logic [DataWidth-1:0]   wdata;
  } bus_req_t;

  // ------------------------------------------------------------------
  // response channel
  // ------------------------------------------------------------------
  // rvalid pulses one cycle after the matching req
  // rdata is zero for writes and for errors
  typedef struct packed {
    logic                 rvalid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } bus_rsp_t;

endpackage

/* rtl/soc_map_pkg.sv */
package soc_map_pkg;

  // ------------------------------------------------------------------
  // address map
  // ------------------------------------------------------------------
  localparam logic [31:0] RomBase     = 32'h0001_0000;
  localparam logic [31:0] RomLength   = 32'h0001_0000;
  localparam logic [31:0] ClintBase   = 32'h0200_0000;
  localparam logic [31:0] ClintLength = 32'h0000_C000;

  // CLINT register offsets, per-hart registers spaced by 8 bytes
  localparam logic [15:0] MsipOffset     = 16'h0000;
  localparam logic [15:0] MtimecmpOffset = 16'h4000;
  localparam logic [15:0] MtimeOffset    = 16'hBFF8;

  // target selected by the router
  typedef enum logic [1:0] {
    REGION_NONE  = 2'd0,
    REGION_ROM   = 2'd1,
    REGION_CLINT = 2'd2
  } region_e;

  // ------------------------------------------------------------------
  // address views
  // ------------------------------------------------------------------
  // boot ROM view, one 64-bit word per index
  typedef struct packed {
    logic [15:0] upper;
    logic [12:0] word_idx;
    logic [2:0]  byte_off;
  } rom_addr_t;

  // CLINT view
  // bank 0 msip, bank 1 mtimecmp, bank 2 holds mtime at its top word
  typedef struct packed {
    logic [15:0] upper;
    logic [1:0]  bank;
    logic [10:0] reg_idx;
    logic [2:0]  byte_off;
  } clint_addr_t;

  // one address word, read as raw bits by the router and
  // through its own view by each target
  typedef union packed {
    logic [31:0] raw;
    rom_addr_t   rom;
    clint_addr_t clint;
  } soc_addr_u;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the peripheral subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_periph_subsystem \
  -f periph_subsystem.f

out="$(./obj_dir/Vtb_periph_subsystem +verilator+error+limit+100 2>&1)" || true
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

/* verif/periph_subsystem_asserts.sv */
`timescale 1ns/10ps

module periph_subsystem_asserts #(
  parameter int unsigned NrHarts = 2
) (
  input logic                  clk_i,
  input logic                  ndmreset_n,
  input soc_bus_pkg::bus_req_t bus_req_i,
  input soc_bus_pkg::bus_rsp_t bus_rsp_i,
  input logic [NrHarts-1:0]    timer_irq_i,
  input logic [NrHarts-1:0]    ipi_i
);

  // failed checks so far
  int unsigned fail_cnt = 0;

  // every request answered on the next edge
  rsp_follows_req: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n) bus_req_i.req |=> bus_rsp_i.rvalid
  ) else begin
    $error("no rvalid one cycle after req");
    fail_cnt++;
  end

  // no response out of nowhere
  rsp_has_req: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n) bus_rsp_i.rvalid |-> $past(bus_req_i.req)
  ) else begin
    $error("rvalid without a req in the previous cycle");
    fail_cnt++;
  end

  irq_low_in_reset: assert property (
    @(posedge clk_i) !ndmreset_n |-> (timer_irq_i == '0) && (ipi_i == '0)
  ) else begin
    $error("interrupt output high during reset");
    fail_cnt++;
  end

endmodule

bind periph_subsystem periph_subsystem_asserts #(
  .NrHarts ( NrHarts )
) i_asserts (
  .clk_i       ( clk_i       ),
  .ndmreset_n  ( ndmreset_n  ),
  .bus_req_i   ( bus_req_i   ),
  .bus_rsp_i   ( bus_rsp_o   ),
  .timer_irq_i ( timer_irq_o ),
  .ipi_i       ( ipi_o       )
);

/* verif/tb_periph_subsystem.sv */
`timescale 1ns/10ps

module tb_periph_subsystem;

  localparam int unsigned NrHarts   = 2;
  localparam int unsigned RomWords  = 16;
  localparam int unsigned IdxW      = $clog2(RomWords);
  localparam logic [31:0] MtimeAddr = soc_map_pkg::ClintBase + 32'(soc_map_pkg::MtimeOffset);
  // rough budget of bus requests and rtc edges over all tests, 4 ns cycle, twice the margin
  localparam int unsigned NrReqs    = 80;
  localparam int unsigned NrRtc     = 16;
  localparam int unsigned TimeoutNs = 2 * 4 * (16 + 2 * NrReqs + 20 * NrRtc + 100);

  logic                  clk;
  logic                  ndmreset_n;
  logic                  rtc;
  soc_bus_pkg::bus_req_t bus_req;
  soc_bus_pkg::bus_rsp_t bus_rsp;
  logic [NrHarts-1:0]    timer_irq;
  logic [NrHarts-1:0]    ipi;

  logic [63:0]           rom_model [RomWords];
  logic [63:0]           mtime_val;
  int                    errors;
  int                    seed;

  periph_subsystem #(
    .NrHarts  ( NrHarts  ),
    .RomWords ( RomWords )
  ) DUT (
    .clk_i       ( clk        ),
    .ndmreset_n  ( ndmreset_n ),
    .rtc_i       ( rtc        ),
    .bus_req_i   ( bus_req    ),
    .bus_rsp_o   ( bus_rsp    ),
    .timer_irq_o ( timer_irq  ),
    .ipi_o       ( ipi        )
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ------------------------------------------------------------------
  // bus access and compare helpers
  // ------------------------------------------------------------------
  function automatic logic [31:0] clint_addr(input logic [15:0] offset, input int unsigned hart);
    return soc_map_pkg::ClintBase + 32'(offset) + 32'(hart * 8);
  endfunction

  function automatic soc_bus_pkg::bus_rsp_t expect_rsp(input logic err,
                                                       input logic [63:0] rdata);
    soc_bus_pkg::bus_rsp_t rsp;
    rsp.rvalid = 1'b1;
    rsp.err    = err;
    rsp.rdata  = rdata;
    return rsp;
  endfunction

  // one request, response sampled at the next falling edge
  task automatic access(input logic we, input logic [31:0] addr, input logic [63:0] wdata,
                        output soc_bus_pkg::bus_rsp_t rsp);
    @(negedge clk);
    bus_req.req      = 1'b1;
    bus_req.we       = we;
    bus_req.addr.raw = addr;
    bus_req.wdata    = wdata;
    @(negedge clk);
    bus_req.req = 1'b0;
    rsp = bus_rsp;
  endtask

  task automatic check_rsp(input soc_bus_pkg::bus_rsp_t got, input soc_bus_pkg::bus_rsp_t exp,
                           input string what);
    if (got !== exp) begin
      $display("ERR %0d ns: %s rvalid/err/rdata %0b/%0b/%h, expected %0b/%0b/%h", $time, what,
               got.rvalid, got.err, got.rdata, exp.rvalid, exp.err, exp.rdata);
      errors++;
    end
  endtask

  task automatic check_irq(input logic [NrHarts-1:0] tmr_exp, input logic [NrHarts-1:0] ipi_exp,
                           input string what);
    if (timer_irq !== tmr_exp || ipi !== ipi_exp) begin
      $display("ERR %0d ns: %s timer_irq %b ipi %b, expected %b %b", $time, what,
               timer_irq, ipi, tmr_exp, ipi_exp);
      errors++;
    end
  endtask

  // rising edges 20 cycles apart, then a short settle
  task automatic rtc_edges(input int unsigned n);
    repeat (n) begin
      @(negedge clk);
      rtc = 1'b1;
      repeat (10) @(negedge clk);
      rtc = 1'b0;
      repeat (9) @(negedge clk);
    end
    repeat (4) @(negedge clk);
  endtask

  // ------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------
  task automatic read_rom_image();
    soc_bus_pkg::bus_rsp_t rsp;
    for (int unsigned i = 0; i < RomWords; i++) begin
      access(1'b0, soc_map_pkg::RomBase + 32'(i * 8), '0, rsp);
      check_rsp(rsp, expect_rsp(1'b0, rom_model[IdxW'(i)]), "rom read");
    end
    access(1'b0, soc_map_pkg::RomBase + 32'(RomWords * 8), '0, rsp);
    check_rsp(rsp, expect_rsp(1'b0, '0), "rom read past image");
  endtask

  task automatic probe_error_accesses();
    soc_bus_pkg::bus_rsp_t rsp;
    logic [63:0]           junk;
    junk = {$random(seed), $random(seed)};
    access(1'b1, soc_map_pkg::RomBase + 32'd8, junk, rsp);
    check_rsp(rsp, expect_rsp(1'b1, '0), "rom write");
    access(1'b0, 32'h3000_0000, '0, rsp);
    check_rsp(rsp, expect_rsp(1'b1, '0), "unmapped read");
    // just below the CLINT base
    access(1'b1, soc_map_pkg::ClintBase - 32'd8, junk, rsp);
    check_rsp(rsp, expect_rsp(1'b1, '0), "unmapped write");
    access(1'b1, clint_addr(soc_map_pkg::MtimecmpOffset, NrHarts), junk, rsp);
    check_rsp(rsp, expect_rsp(1'b1, '0), "undefined clint write");
    access(1'b0, clint_addr(soc_map_pkg::MsipOffset, NrHarts), '0, rsp);
    check_rsp(rsp, expect_rsp(1'b1, '0), "undefined clint read");
    // nothing moved
    access(1'b0, soc_map_pkg::RomBase + 32'd8, '0, rsp);
    check_rsp(rsp, expect_rsp(1'b0, rom_model[1]), "rom after write");
    for (int h = 0; h < NrHarts; h++) begin
      access(1'b0, clint_addr(soc_map_pkg::MtimecmpOffset, h), '0, rsp);
      check_rsp(rsp, expect_rsp(1'b0, '1), "mtimecmp after errors");
    end
  endtask

  task automatic count_mtime_ticks(input int unsigned k);
    soc_bus_pkg::bus_rsp_t rsp;
    logic [63:0]           v;
    v = {$random(seed), $random(seed)};
    access(1'b1, MtimeAddr, v, rsp);
    check_rsp(rsp, expect_rsp(1'b0, '0), "mtime write");
    rtc_edges(2 * k);
    access(1'b0, MtimeAddr, '0, rsp);
    check_rsp(rsp, expect_rsp(1'b0, v + 64'(k)), "mtime count");
  endtask

  task automatic raise_timer_irq();
    soc_bus_pkg::bus_rsp_t rsp;
    access(1'b1, MtimeAddr, 64'd100, rsp);
    check_rsp(rsp, expect_rsp(1'b0, '0), "mtime write");
    for (int h = 0; h < NrHarts; h++) begin
      access(1'b1, clint_addr(soc_map_pkg::MtimecmpOffset, h), 64'(102 + h), rsp);
      check_rsp(rsp, expect_rsp(1'b0, '0), "mtimecmp write");
    end
    // two rtc edges per mtime step
    rtc_edges(2);
    check_irq('0, '0, "mtime 101");
    rtc_edges(2);
    check_irq(NrHarts'(1), '0, "mtime 102");
    rtc_edges(2);
    check_irq('1, '0, "mtime 103");
    mtime_val = 64'd103;
    for (int h = 0; h < NrHarts; h++) begin
      access(1'b1, clint_addr(soc_map_pkg::MtimecmpOffset, h), '1, rsp);
      check_rsp(rsp, expect_rsp(1'b0, '0), "mtimecmp reset");
    end
    repeat (2) @(negedge clk);
    check_irq('0, '0, "mtimecmp all ones");
  endtask

  task automatic toggle_soft_irq();
    soc_bus_pkg::bus_rsp_t rsp;
    logic [63:0]           wval;
    for (int h = 0; h < NrHarts; h++) begin
      wval = {$random(seed), $random(seed)} | 64'd1;
      access(1'b1, clint_addr(soc_map_pkg::MsipOffset, h), wval, rsp);
      check_rsp(rsp, expect_rsp(1'b0, '0), "msip set");
      check_irq('0, NrHarts'(1) << h, "msip set");
      access(1'b0, clint_addr(soc_map_pkg::MsipOffset, h), '0, rsp);
      check_rsp(rsp, expect_rsp(1'b0, 64'd1), "msip readback set");
      access(1'b1, clint_addr(soc_map_pkg::MsipOffset, h), wval & ~64'd1, rsp);
      check_rsp(rsp, expect_rsp(1'b0, '0), "msip clear");
      check_irq('0, '0, "msip clear");
      access(1'b0, clint_addr(soc_map_pkg::MsipOffset, h), '0, rsp);
      check_rsp(rsp, expect_rsp(1'b0, '0), "msip readback clear");
    end
  endtask

  // one read per cycle, responses checked in order
  task automatic stream_back_to_back(input int unsigned n);
    soc_bus_pkg::bus_rsp_t exp_q[$];
    logic [31:0]           addr;
    int unsigned           pick;
    int unsigned           hart;
    int unsigned           idx;
    for (int unsigned i = 0; i <= n; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_rsp(bus_rsp, exp_q.pop_front(), "back-to-back read");
      end
      bus_req.req = (i < n);
      bus_req.we  = 1'b0;
      if (i < n) begin
        pick = $unsigned($random(seed)) % 4;
        hart = $unsigned($random(seed)) % NrHarts;
        idx  = $unsigned($random(seed)) % RomWords;
        case (pick)
          0: begin
            addr = soc_map_pkg::RomBase + 32'(idx * 8);
            exp_q.push_back(expect_rsp(1'b0, rom_model[IdxW'(idx)]));
          end
          1: begin
            addr = clint_addr(soc_map_pkg::MtimecmpOffset, hart);
            exp_q.push_back(expect_rsp(1'b0, '1));
          end
          2: begin
            addr = clint_addr(soc_map_pkg::MsipOffset, hart);
            exp_q.push_back(expect_rsp(1'b0, '0));
          end
          default: begin
            addr = MtimeAddr;
            exp_q.push_back(expect_rsp(1'b0, mtime_val));
          end
        endcase
        bus_req.addr.raw = addr;
      end
    end
  endtask

  // ------------------------------------------------------------------
  // sequence and verdict
  // ------------------------------------------------------------------
  initial begin
    seed       = 76;
    errors     = 0;
    mtime_val  = '0;
    ndmreset_n = 1'b0;
    rtc        = 1'b0;
    bus_req    = '0;
    $readmemh("boot_rom.hex", rom_model);
    repeat (16) @(negedge clk);
    ndmreset_n = 1'b1;
    check_irq('0, '0, "after reset");
    read_rom_image();
    probe_error_accesses();
    count_mtime_ticks(3);
    raise_timer_irq();
    toggle_soft_irq();
    stream_back_to_back(24);
    @(negedge clk);
    $display("errors: %0d compare, %0d assertion", errors, DUT.i_asserts.fail_cnt);
    if (errors == 0 && DUT.i_asserts.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TimeoutNs);
    $display("timeout: the run did not finish within %0d ns", TimeoutNs);
    $display("*** FAILED ***");
    $finish;
  end

endmodule
